// File: design/ifu_pkg.sv
package ifu_pkg;

  localparam int xlen = 32;

  // Fetch address split. Bits 1..0 are ignored and bit 2 picks the word in a two-word line
  localparam int word_bit  = 2;
  localparam int index_lsb = 3;

  // The index takes the next l1i_len bits and the tag keeps whatever is left above it
  function automatic int tag_width(input int l1i_len);
    return xlen - index_lsb - l1i_len;
  endfunction

  // One fetched instruction together with the address it came from
  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] inst;
  } fetch_t;

  // Read request toward memory, lock is held for the whole refill
  typedef struct packed {
    logic [xlen-1:0] addr;
    logic            valid;
    logic            lock;
  } bus_req_t;

endpackage

// File: design/ifu_pc_gen.sv
`timescale 1ns/1ps

module ifu_pc_gen
  import ifu_pkg::*;
#(
  parameter logic [xlen-1:0] reset_pc = 32'h8000_0000
) (
  input  logic            clock,
  input  logic            reset,
  input  logic            take,
  input  logic            redirect,
  input  logic [xlen-1:0] target,
  output logic [xlen-1:0] pc
);

  logic [xlen-1:0] pc_next;

  // A redirect wins over a word taken in the same cycle
  always_comb begin
    pc_next = pc;
    if (redirect) begin
      pc_next = target;
    end else if (take) begin
      pc_next = pc + xlen'(4);
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= reset_pc;
    end else begin
      pc <= pc_next;
    end
  end

  // Instructions are 32 bits wide, so the fetch address never leaves a word boundary
  a_pc_aligned: assert property (
    @(posedge clock) disable iff (reset)
    pc[1:0] == 2'b00
  );

endmodule

// File: design/ifu_l1i.sv
`timescale 1ns/1ps

module ifu_l1i
  import ifu_pkg::*;
#(
  parameter int l1i_len = 4
) (
  input  logic            clock,
  input  logic            reset,
  input  logic [xlen-1:0] pc,
  input  logic            redirect,
  input  logic            fence_i,
  input  logic            bus_ready,
  input  logic [xlen-1:0] rdata,
  input  logic            rdata_valid,
  output bus_req_t        req,
  output logic            hit,
  output fetch_t          fetch,
  output logic            ready
);

  localparam int lines = 2 ** l1i_len;
  localparam int tag_w = tag_width(l1i_len);

  typedef enum logic [2:0] {
    st_idle = 3'd0,
    st_rd0  = 3'd1,
    st_gap  = 3'd2,
    st_rd1  = 3'd3,
    st_wb   = 3'd4
  } state_t;

  state_t state;

  logic [xlen-1:0]    data_mem [lines][2];
  logic [tag_w-1:0]   tag_mem [lines];
  logic [lines-1:0]   line_valid;

  logic               fetch_armed;
  logic               pend_redirect;
  logic               pend_fence;
  logic [xlen-1:0]    saved_pc;

  logic [xlen-1:0]    addr;
  logic [tag_w-1:0]   addr_tag;
  logic [l1i_len-1:0] addr_idx;
  logic               addr_word;
  logic               second_half;
  logic               line_hit;
  logic               lookup_en;
  logic               refill_busy;
  logic               accept;
  logic               latch_redirect;
  logic               clear_now;
  logic               rd0_beat;
  logic               rd1_beat;

  // While a redirect is pending the refill keeps working on the line it started
  assign addr      = pend_redirect ? saved_pc : pc;
  assign addr_word = addr[word_bit];
  assign addr_idx  = addr[index_lsb +: l1i_len];
  assign addr_tag  = addr[xlen-1 -: tag_w];

  assign line_hit    = line_valid[addr_idx] && (tag_mem[addr_idx] == addr_tag);
  assign lookup_en   = (state == st_idle) || (state == st_wb);
  assign refill_busy = (state == st_rd0) || (state == st_gap) || (state == st_rd1);

  // No word is handed on while a flush or a fence is still waiting for the refill to end
  assign hit = lookup_en && line_hit && !redirect && !fence_i &&
               !pend_redirect && !pend_fence;

  assign fetch.pc   = addr;
  assign fetch.inst = data_mem[addr_idx][addr_word];

  assign second_half = !((state == st_idle) || (state == st_rd0));

  always_comb begin
    req.addr  = {addr[xlen-1:index_lsb], second_half, 2'b00};
    req.valid = fetch_armed && !line_hit &&
                (((state == st_idle) && !redirect) || (state == st_rd0));
    req.lock  = (state != st_idle);
  end

  assign ready = (state == st_idle);

  assign accept         = (state == st_idle) && req.valid && bus_ready;
  assign latch_redirect = redirect && refill_busy && !pend_redirect;
  // With nothing in flight a fence clears the valid bits right away
  assign clear_now      = fence_i && !refill_busy && !accept;
  assign rd0_beat       = (state == st_rd0) && rdata_valid;
  assign rd1_beat       = (state == st_rd1) && rdata_valid;

  always_ff @(posedge clock) begin
    if (reset) begin
      state         <= st_idle;
      fetch_armed   <= 1'b0;
      pend_redirect <= 1'b0;
      pend_fence    <= 1'b0;
      line_valid    <= '0;
    end else begin
      fetch_armed <= 1'b1;
      if (latch_redirect) begin
        pend_redirect <= 1'b1;
      end
      if (fence_i && (refill_busy || accept)) begin
        pend_fence <= 1'b1;
      end
      if (clear_now) begin
        line_valid <= '0;
      end
      case (state)
        st_idle: begin
          if (accept) begin
            state <= st_rd0;
          end
        end
        st_rd0: begin
          if (rdata_valid) begin
            state <= st_gap;
          end
        end
        st_gap: begin
          state <= st_rd1;
        end
        st_rd1: begin
          if (rdata_valid) begin
            state                <= st_wb;
            line_valid[addr_idx] <= 1'b1;
          end
        end
        st_wb: begin
          state         <= st_idle;
          pend_redirect <= 1'b0;
          pend_fence    <= 1'b0;
          if (pend_fence) begin
            line_valid <= '0;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // Payload side. The old pc is kept from the first redirect seen during a refill
  always_ff @(posedge clock) begin
    if (latch_redirect) begin
      saved_pc <= pc;
    end
    if (rd0_beat) begin
      data_mem[addr_idx][0] <= rdata;
    end
    if (rd1_beat) begin
      data_mem[addr_idx][1] <= rdata;
      tag_mem[addr_idx]     <= addr_tag;
    end
  end

  // Memory may only return data for a read that has been accepted
  a_no_rdata_idle: assert property (
    @(posedge clock) disable iff (reset)
    (state == st_idle) |-> !rdata_valid
  );

  // The refill stays on its line until the write-back, even across a redirect
  a_refill_line_held: assert property (
    @(posedge clock) disable iff (reset)
    refill_busy |=> $stable(addr[xlen-1:index_lsb])
  );

endmodule

// File: design/ifu_out_stage.sv
`timescale 1ns/1ps

module ifu_out_stage
  import ifu_pkg::*;
(
  input  logic   clock,
  input  logic   reset,
  input  logic   hit,
  input  fetch_t fetch_in,
  input  logic   stall,
  input  logic   redirect,
  output logic   take,
  output logic   out_valid,
  output fetch_t out
);

  // A word is taken only when decode can move and the path is not being flushed
  assign take = hit && !stall && !redirect;

  always_ff @(posedge clock) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (redirect) begin
      out_valid <= 1'b0;
    end else if (!stall) begin
      out_valid <= take;
    end
  end

  always_ff @(posedge clock) begin
    if (take) begin
      out <= fetch_in;
    end
  end

  // Decode must see the same word for as long as it holds the stall
  a_hold_on_stall: assert property (
    @(posedge clock) disable iff (reset)
    (stall && out_valid) |=> $stable(out)
  );

endmodule

// File: design/ifu_top.sv
`timescale 1ns/1ps

module ifu_top
  import ifu_pkg::*;
#(
  parameter int              l1i_len  = 4,
  parameter logic [xlen-1:0] reset_pc = 32'h8000_0000
) (
  input  logic            clock,
  input  logic            reset,
  input  logic            redirect,
  input  logic [xlen-1:0] target,
  input  logic            fence_i,
  input  logic            stall,
  input  logic            bus_ready,
  input  logic [xlen-1:0] rdata,
  input  logic            rdata_valid,
  output bus_req_t        req,
  output logic            out_valid,
  output fetch_t          out
);

  logic [xlen-1:0] pc;
  logic            take;
  logic            hit;
  fetch_t          fetch;
  // Idle level of the cache
  logic            l1i_ready;

  ifu_pc_gen #(
    .reset_pc (reset_pc)
  ) u_pc_gen (
    .clock    (clock),
    .reset    (reset),
    .take     (take),
    .redirect (redirect),
    .target   (target),
    .pc       (pc)
  );

  ifu_l1i #(
    .l1i_len (l1i_len)
  ) u_l1i (
    .clock       (clock),
    .reset       (reset),
    .pc          (pc),
    .redirect    (redirect),
    .fence_i     (fence_i),
    .bus_ready   (bus_ready),
    .rdata       (rdata),
    .rdata_valid (rdata_valid),
    .req         (req),
    .hit         (hit),
    .fetch       (fetch),
    .ready       (l1i_ready)
  );

  ifu_out_stage u_out_stage (
    .clock     (clock),
    .reset     (reset),
    .hit       (hit),
    .fetch_in  (fetch),
    .stall     (stall),
    .redirect  (redirect),
    .take      (take),
    .out_valid (out_valid),
    .out       (out)
  );

endmodule

// File: sim/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
  parameter int reset_cycles = 8
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clock);
    #1;
    reset = 1'b0;
  end

endmodule

// File: sim/tb_mem.sv
`timescale 1ns/1ps

module tb_mem
  import ifu_pkg::*;
(
  input  logic            clock,
  input  logic            reset,
  input  bus_req_t        req,
  output logic            bus_ready,
  output logic [xlen-1:0] rdata,
  output logic            rdata_valid
);

  localparam logic [xlen-1:0] key = 32'h1357_9bdf;

  logic [31:0] lcg_state = 32'hcd37_2592;

  function automatic logic [31:0] lcg_next(input logic [31:0] x);
    return x * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic wait_random(input int max_cycles);
    int n;
    lcg_state = lcg_next(lcg_state);
    n = int'(lcg_state[17:16]) % (max_cycles + 1);
    repeat (n) begin
      @(posedge clock);
      #1;
    end
  endtask

  // Every word of memory holds its own address scrambled by the key
  task automatic send_beat();
    rdata       = req.addr ^ key;
    rdata_valid = 1'b1;
    @(posedge clock);
    #1;
    rdata_valid = 1'b0;
    rdata       = '0;
  endtask

  initial begin
    bus_ready   = 1'b0;
    rdata       = '0;
    rdata_valid = 1'b0;
    forever begin
      @(posedge clock);
      #1;
      if (reset) begin
        bus_ready = 1'b0;
      end else if (req.lock) begin
        // The refill has been accepted, so both words follow
        bus_ready = 1'b0;
        wait_random(3);
        send_beat();
        @(posedge clock);
        #1;
        wait_random(3);
        send_beat();
      end else begin
        lcg_state = lcg_next(lcg_state);
        bus_ready = lcg_state[20];
      end
    end
  end

endmodule

// File: sim/tb_ifu.sv
`timescale 1ns/1ps

module tb_ifu
  import ifu_pkg::*;
();

  localparam logic [xlen-1:0] key = 32'h1357_9bdf;
  localparam int timeout_cycles = 400;

  logic            clock;
  logic            reset;
  logic            redirect;
  logic [xlen-1:0] target;
  logic            fence_i;
  logic            stall;
  logic            bus_ready;
  logic [xlen-1:0] rdata;
  logic            rdata_valid;
  bus_req_t        req;
  logic            out_valid;
  fetch_t          out;

  logic [31:0]     golden [0:127];
  logic [xlen-1:0] exp_pc;
  logic [xlen-1:0] first_beat_addr;
  fetch_t          last_word;
  int              reads = 0;
  int              words_seen = 0;

  tb_clock u_clock (
    .clock (clock),
    .reset (reset)
  );

  tb_mem u_mem (
    .clock       (clock),
    .reset       (reset),
    .req         (req),
    .bus_ready   (bus_ready),
    .rdata       (rdata),
    .rdata_valid (rdata_valid)
  );

  ifu_top #(
    .l1i_len  (4),
    .reset_pc (32'h8000_0000)
  ) u_dut (
    .clock       (clock),
    .reset       (reset),
    .redirect    (redirect),
    .target      (target),
    .fence_i     (fence_i),
    .stall       (stall),
    .bus_ready   (bus_ready),
    .rdata       (rdata),
    .rdata_valid (rdata_valid),
    .req         (req),
    .out_valid   (out_valid),
    .out         (out)
  );

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (expected === actual) else begin
      stop_with_failure($sformatf("** Error %s: expected %h, actual %h",
                                  name, expected, actual));
    end
  endtask

  // A refill reads word 0 of the line and then word 1
  always @(negedge clock) begin
    if (!reset && rdata_valid) begin
      if (reads % 2 == 0) begin
        check_value("first beat bit 2", 32'd0, 32'(req.addr[2]));
        first_beat_addr = req.addr;
      end else begin
        check_value("second beat address", first_beat_addr | 32'h4, req.addr);
      end
      reads = reads + 1;
    end
  end

  // Advance one cycle and check whatever decode sees in it
  task automatic step();
    @(posedge clock);
    #1;
    if (out_valid && !stall) begin
      check_value("fetch pc", exp_pc, out.pc);
      check_value("fetch inst", exp_pc ^ key, out.inst);
      last_word  = out;
      exp_pc     = exp_pc + 32'd4;
      words_seen = words_seen + 1;
    end else if (out_valid && stall) begin
      check_value("held pc", last_word.pc, out.pc);
      check_value("held inst", last_word.inst, out.inst);
    end
  endtask

  task automatic run_words(input int n);
    int goal;
    int waited;
    goal   = words_seen + n;
    waited = 0;
    stall  = 1'b0;
    while (words_seen < goal) begin
      if (waited == timeout_cycles) begin
        stop_with_failure("Timeout while waiting for fetched words");
      end
      step();
      waited++;
    end
    stall = 1'b1;
  endtask

  task automatic wait_settled();
    int waited;
    waited = 0;
    while (req.valid || req.lock) begin
      if (waited == timeout_cycles) begin
        stop_with_failure("Timeout while waiting for the cache to finish its refill");
      end
      step();
      waited++;
    end
  endtask

  task automatic wait_refill_started();
    int waited;
    waited = 0;
    while (!req.lock) begin
      if (waited == timeout_cycles) begin
        stop_with_failure("Timeout while waiting for a refill to start");
      end
      step();
      waited++;
    end
  endtask

  task automatic pulse_redirect(input logic [xlen-1:0] t);
    target   = t;
    redirect = 1'b1;
    exp_pc   = t;
    step();
    redirect = 1'b0;
  endtask

  initial begin
    int line;
    int waited;
    logic [31:0] cmd;
    logic [31:0] arg;
    redirect  = 1'b0;
    target    = '0;
    fence_i   = 1'b0;
    stall     = 1'b1;
    exp_pc    = 32'h8000_0000;
    last_word = '0;
    for (int i = 0; i < 128; i++) begin
      golden[i] = '0;
    end
    $readmemh("sim/ifu_golden.txt", golden);

    waited = 0;
    while (reset) begin
      if (waited == timeout_cycles) begin
        stop_with_failure("Timeout while waiting for reset to end");
      end
      step();
      waited++;
      if (reset) begin
        check_value("out_valid in reset", 32'd0, 32'(out_valid));
        check_value("bus valid in reset", 32'd0, 32'(req.valid));
        check_value("lock in reset", 32'd0, 32'(req.lock));
        check_value("ready in reset", 32'd1, 32'(u_dut.l1i_ready));
        check_value("take in reset", 32'd0, 32'(u_dut.take));
      end
    end

    line = 0;
    while (line < 32 && golden[line*4] != 32'd0) begin
      cmd = golden[line*4];
      arg = golden[line*4+1];
      case (cmd)
        32'd1: run_words(int'(arg));
        32'd2: begin
          wait_settled();
          pulse_redirect(arg);
        end
        32'd3: begin
          wait_settled();
          fence_i = 1'b1;
          step();
          fence_i = 1'b0;
        end
        32'd4: begin
          wait_settled();
          repeat (int'(arg)) step();
        end
        32'd5: begin
          wait_refill_started();
          pulse_redirect(arg);
        end
        default: stop_with_failure($sformatf("Unknown command on golden line %0d", line));
      endcase
      check_value($sformatf("line %0d next pc", line), golden[line*4+2], u_dut.pc);
      if (golden[line*4+3] != 32'hffff_ffff) begin
        check_value($sformatf("line %0d bus reads", line), golden[line*4+3], 32'(reads));
      end
      line++;
    end

    $display("TEST PASS");
    $finish;
  end

endmodule

// File: sources.f
design/ifu_pkg.sv
design/ifu_pc_gen.sv
design/ifu_l1i.sv
design/ifu_out_stage.sv
design/ifu_top.sv
sim/tb_clock.sv
sim/tb_mem.sv
sim/tb_ifu.sv

// File: Makefile
TOP = tb_ifu

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -Mdir obj_dir

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASS$$"

lint:
	verilator --lint-only --timing -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: sim/ifu_golden.txt
// command argument expected_next_pc expected_bus_reads, all hex
// 1 run words, 2 redirect, 3 fence, 4 stall cycles, 5 redirect during refill, ffffffff skips reads
1 8 80000020 8
4 5 80000020 a
1 4 80000030 c
2 80000000 80000000 e
1 e 80000038 e
3 0 80000038 10
2 80000000 80000000 12
1 4 80000010 16
5 80000100 80000100 ffffffff
1 6 80000118 1e
4 3 80000118 20
1 2 80000120 20
5 80000004 80000004 ffffffff
1 3 80000010 26
4 4 80000010 28
1 4 80000020 2a
0 0 0 0
